// ==== project.f ====
+incdir+hdl
hdl/spi_bus_pkg.sv
hdl/spi_link_pkg.sv
hdl/spi_sclk_timer.sv
hdl/spi_shifter.sv
hdl/spi_xcvr.sv
hdl/spi_master.sv
verif/spi_tb_clock.sv
verif/spi_slave_model.sv
verif/spi_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SPI master testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module spi_tb -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/Vspi_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "Simulation run ended with status $sim_status"
  exit 1
fi

exit 0

// ==== verif/spi_tb.sv ====
`default_nettype none

`include "spi_defs.svh"

module spi_tb;

  localparam int CLKFREQ       = 4;
  localparam int SPEED         = 1;  // Two clocks per sclk phase
  localparam int HALF_PERIOD   = CLKFREQ / (2 * SPEED);
  localparam int CLK_PERIOD    = 40;
  localparam int FIXED_ROWS    = 4;
  localparam int NUM_ROWS      = 8;
  localparam int WATCHDOG_TIME = NUM_ROWS * (16 * HALF_PERIOD + 20) * CLK_PERIOD;

  typedef struct {
    spi_link_pkg::conf_t conf;
    spi_link_pkg::ss_t   ss;
    spi_link_pkg::byte_t tx;
    spi_link_pkg::byte_t reply;
  } row_t;

  logic                clk;
  logic                rst_n;
  logic                miso;
  logic                mosi;
  logic                sclk;
  spi_link_pkg::ss_t   ss;
  spi_bus_pkg::word_t  data_in;
  spi_bus_pkg::word_t  data_out;
  logic                write;
  logic                select;
  spi_bus_pkg::addr_t  address;
  logic                slave_ss_n;
  spi_link_pkg::conf_t mode_conf;    // Mode the slave follows
  spi_link_pkg::byte_t slave_reply;
  spi_link_pkg::byte_t slave_rx;
  logic [15:0]         lfsr_state;
  row_t                rows [NUM_ROWS];
  spi_bus_pkg::word_t  rd;

  assign slave_ss_n = &ss;  // Either select picks the slave

  spi_tb_clock clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  spi_master #(
    .clkfreq(CLKFREQ),
    .speed  (SPEED)
  ) spi_master_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .miso     (miso),
    .mosi     (mosi),
    .sclk     (sclk),
    .ss       (ss),
    .data_in  (data_in),
    .data_out (data_out),
    .write    (write),
    .select   (select),
    .address  (address)
  );

  spi_slave_model slave (
    .sclk      (sclk),
    .ss_n      (slave_ss_n),
    .mosi      (mosi),
    .cpol      (mode_conf[`SPI_CONF_CPOL]),
    .cpha      (mode_conf[`SPI_CONF_CPHA]),
    .lsb_first (mode_conf[`SPI_CONF_LSB_FIRST]),
    .reply     (slave_reply),
    .miso      (miso),
    .rx_byte   (slave_rx)
  );

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    $display("Simulation FAILED");
    $fatal(1, "Value mismatch on %s", name);
  endtask

  task automatic check_word(input string name, input spi_bus_pkg::word_t got,
                            input spi_bus_pkg::word_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_byte(input string name, input spi_link_pkg::byte_t got,
                            input spi_link_pkg::byte_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_state(input string name, input spi_link_pkg::xfer_state_t got,
                             input spi_link_pkg::xfer_state_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_ss(input string name, input spi_link_pkg::ss_t got,
                          input spi_link_pkg::ss_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_byte(output spi_link_pkg::byte_t b);
    for (int k = 0; k < 8; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  // Each bus cycle stays on the bus until the next call
  task automatic bus_write(input spi_bus_pkg::addr_t a, input spi_bus_pkg::word_t d);
    @(posedge clk);
    select  <= 1'b1;
    write   <= 1'b1;
    address <= a;
    data_in <= d;
  endtask

  task automatic bus_read(input spi_bus_pkg::addr_t a, output spi_bus_pkg::word_t d);
    @(posedge clk);
    select  <= 1'b1;
    write   <= 1'b0;
    address <= a;
    @(negedge clk);
    d = data_out;
  endtask

  task automatic bus_idle();
    @(posedge clk);
    select <= 1'b0;
    write  <= 1'b0;
  endtask

  task automatic build_table();
    rows[0] = '{16'h0000, 2'b10, 8'hA5, 8'h3C};  // Mode 0, MSB first
    rows[1] = '{16'h0001, 2'b01, 8'h81, 8'h7E};  // Mode 2
    rows[2] = '{16'h0002, 2'b10, 8'h1F, 8'hC8};  // Mode 1, MSB first
    rows[3] = '{16'h0003, 2'b01, 8'hD2, 8'h4B};  // Mode 3, MSB first
    // Random rows take all four modes LSB first
    for (int i = FIXED_ROWS; i < NUM_ROWS; i++) begin
      rows[i].conf = spi_link_pkg::conf_t'(i);
      rows[i].ss   = i[0] ? 2'b01 : 2'b10;
      draw_byte(rows[i].tx);
      draw_byte(rows[i].reply);
    end
  endtask

  task automatic run_transfer(input row_t r);
    spi_bus_pkg::word_t        rd_t;
    spi_link_pkg::xfer_state_t st;
    mode_conf   = r.conf;
    slave_reply = r.reply;
    bus_write(`SPI_ADDR_CONF, r.conf);
    bus_read(`SPI_ADDR_CONF, rd_t);
    check_word("conf register", rd_t, r.conf);
    bus_write(`SPI_ADDR_SS, {14'b0, r.ss});
    @(negedge clk);
    check_bit("sclk idle level", sclk, r.conf[`SPI_CONF_CPOL]);
    bus_read(`SPI_ADDR_SS, rd_t);
    check_word("ss register", rd_t, {14'b0, r.ss});
    check_ss("ss", ss, r.ss);
    bus_write(`SPI_ADDR_DATA, {8'h00, r.tx});
    bus_read(`SPI_ADDR_DATA, rd_t);
    check_state("state", spi_link_pkg::xfer_state_t'(rd_t[15:14]), spi_link_pkg::XFER_BUSY);
    bus_write(`SPI_ADDR_DATA, {8'h00, ~r.tx});  // Ignored while busy
    st = spi_link_pkg::XFER_BUSY;
    while (st != spi_link_pkg::XFER_COMPLETE) begin
      bus_read(`SPI_ADDR_DATA, rd_t);
      st = spi_link_pkg::xfer_state_t'(rd_t[15:14]);
      if (st != spi_link_pkg::XFER_COMPLETE)
        check_state("state", st, spi_link_pkg::XFER_BUSY);
    end
    check_word("status", rd_t, {spi_link_pkg::XFER_COMPLETE, 6'b000000, r.reply});
    check_byte("slave rx_byte", slave_rx, r.tx);
    bus_idle();  // Releases the result
    @(negedge clk);
    check_word("data_out without read", data_out, 16'h0000);
    check_bit("sclk idle level", sclk, r.conf[`SPI_CONF_CPOL]);
    bus_read(`SPI_ADDR_DATA, rd_t);
    check_state("state", spi_link_pkg::xfer_state_t'(rd_t[15:14]), spi_link_pkg::XFER_IDLE);
    check_byte("received byte", rd_t[7:0], r.reply);
    bus_write(`SPI_ADDR_SS, 16'h0003);
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("Simulation FAILED");
    $fatal(1, "Watchdog expired before all transfers finished");
  end

  initial begin
    select      <= 1'b0;
    write       <= 1'b0;
    address     <= '0;
    data_in     <= '0;
    mode_conf   = '0;
    slave_reply = '0;
    lfsr_state  = 16'd55376;
    build_table();
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_bit("sclk", sclk, 1'b0);
    check_ss("ss", ss, `SPI_SS_RESET);
    bus_read(`SPI_ADDR_DATA, rd);
    check_state("state", spi_link_pkg::xfer_state_t'(rd[15:14]), spi_link_pkg::XFER_IDLE);
    check_word("status", rd, 16'h0000);
    bus_read(`SPI_ADDR_SS, rd);
    check_word("ss register", rd, 16'h0003);
    bus_read(`SPI_ADDR_CONF, rd);
    check_word("conf register", rd, 16'h0000);
    // Register write and read-back
    bus_write(`SPI_ADDR_SS, 16'h0002);
    bus_read(`SPI_ADDR_SS, rd);
    check_word("ss register", rd, 16'h0002);
    check_ss("ss", ss, 2'b10);
    bus_write(`SPI_ADDR_SS, 16'h0003);
    bus_write(`SPI_ADDR_CONF, 16'h5A36);
    bus_read(`SPI_ADDR_CONF, rd);
    check_word("conf register", rd, 16'h5A36);
    for (int i = 0; i < NUM_ROWS; i++)
      run_transfer(rows[i]);
    bus_idle();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/spi_slave_model.sv ====
`default_nettype none

module spi_slave_model (
  input  wire                 sclk,
  input  wire                 ss_n,
  input  wire                 mosi,
  input  wire                 cpol,
  input  wire                 cpha,
  input  wire                 lsb_first,
  input  spi_link_pkg::byte_t reply,
  output logic                miso,
  output spi_link_pkg::byte_t rx_byte
);

  spi_link_pkg::byte_t tx_sr;

  // Next reply bit onto miso
  task automatic present_bit();
    if (lsb_first) begin
      miso  = tx_sr[0];
      tx_sr = tx_sr >> 1;
    end else begin
      miso  = tx_sr[7];
      tx_sr = tx_sr << 1;
    end
  endtask

  initial begin
    miso    = 1'b0;
    rx_byte = '0;
    tx_sr   = '0;
    forever begin
      @(negedge ss_n);
      tx_sr   = reply;
      rx_byte = '0;
      if (!cpha)
        present_bit();  // First bit must be there before the leading edge
      while (!ss_n) begin
        @(sclk or ss_n);
        if (!ss_n) begin
          // Leading edge leaves the idle level
          if ((sclk != cpol) != cpha)
            rx_byte = lsb_first ? {mosi, rx_byte[7:1]} : {rx_byte[6:0], mosi};
          else
            present_bit();
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/spi_tb_clock.sv ====
`default_nettype none

module spi_tb_clock #(
  parameter int half_cycle = 20  // Period of 40
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #half_cycle clk = ~clk;
  end

  // Reset held low for the first three rising edges
  initial begin
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== hdl/spi_master.sv ====
`default_nettype none

`include "spi_defs.svh"

module spi_master #(
  parameter int clkfreq = `SPI_DEF_CLKFREQ,
  parameter int speed   = `SPI_DEF_SPEED
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  miso,
  output logic                 mosi,
  output logic                 sclk,
  output spi_link_pkg::ss_t    ss,
  input  spi_bus_pkg::word_t   data_in,
  output spi_bus_pkg::word_t   data_out,
  input  wire                  write,
  input  wire                  select,
  input  spi_bus_pkg::addr_t   address
);

  // System clocks per sclk phase
  localparam int HALF_PERIOD = clkfreq / (2 * speed);

  spi_link_pkg::conf_t       conf;
  spi_link_pkg::byte_t       rx_q;    // Last received byte, read at address 0
  spi_link_pkg::byte_t       xcvr_rx;
  spi_link_pkg::xfer_state_t state;
  spi_link_pkg::xfer_state_t state_next;
  logic                      start;
  logic                      xcvr_done;
  logic                      bus_wr;
  logic                      bus_rd;

  assign bus_wr = select & write;
  assign bus_rd = select & ~write;

  // Transfer control, start is taken straight from the accepted write
  always_comb begin
    state_next = state;
    start      = 1'b0;
    if (bus_wr && address == `SPI_ADDR_DATA && state == spi_link_pkg::XFER_IDLE) begin
      start      = 1'b1;
      state_next = spi_link_pkg::XFER_BUSY;
    end
    // Status read acknowledges the result
    if (bus_rd && address == `SPI_ADDR_DATA && state == spi_link_pkg::XFER_COMPLETE)
      state_next = spi_link_pkg::XFER_RELEASE;
    if (!select && state == spi_link_pkg::XFER_RELEASE)
      state_next = spi_link_pkg::XFER_IDLE;
    if (xcvr_done && state == spi_link_pkg::XFER_BUSY)
      state_next = spi_link_pkg::XFER_COMPLETE;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= spi_link_pkg::XFER_IDLE;
      rx_q  <= '0;
      ss    <= `SPI_SS_RESET;
      conf  <= '0;
    end else begin
      state <= state_next;
      if (xcvr_done && state == spi_link_pkg::XFER_BUSY)
        rx_q <= xcvr_rx;  // Held until the next transfer completes
      if (bus_wr && address == `SPI_ADDR_SS)
        ss <= data_in[1:0];
      if (bus_wr && address == `SPI_ADDR_CONF)
        conf <= data_in;
    end
  end

  // Read mux, zero when the bus is not reading
  always_comb begin
    data_out = '0;
    if (bus_rd) begin
      case (address)
        `SPI_ADDR_DATA: data_out = {state, 6'b000000, rx_q};
        `SPI_ADDR_SS:   data_out = {14'b0, ss};
        `SPI_ADDR_CONF: data_out = conf;
        default:        data_out = '0;
      endcase
    end
  end

  spi_xcvr #(
    .half_period(HALF_PERIOD)
  ) xcvr0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .conf    (conf),
    .start   (start),
    .tx_byte (data_in[7:0]),
    .done    (xcvr_done),
    .rx_byte (xcvr_rx),
    .miso    (miso),
    .mosi    (mosi),
    .sclk    (sclk)
  );

endmodule

`default_nettype wire

// ==== hdl/spi_xcvr.sv ====
`default_nettype none

`include "spi_defs.svh"

module spi_xcvr #(
  parameter int half_period = 2
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  spi_link_pkg::conf_t  conf,
  input  wire                  start,
  input  spi_link_pkg::byte_t  tx_byte,
  output logic                 done,
  output spi_link_pkg::byte_t  rx_byte,
  input  wire                  miso,
  output logic                 mosi,
  output logic                 sclk
);

  spi_link_pkg::edge_state_t state;
  logic [3:0]                edge_cnt;  // Sixteen sclk edges per byte
  logic                      run;
  logic                      tick;
  logic                      cpol;
  logic                      cpha;
  logic                      lead_edge;
  logic                      shift_out;
  logic                      sample;

  assign cpol = conf[`SPI_CONF_CPOL];
  assign cpha = conf[`SPI_CONF_CPHA];

  assign run       = (state == spi_link_pkg::EDGE_SHIFT);
  assign lead_edge = ~edge_cnt[0];  // Even edges leave the idle level

  // With cpha 0 the first bit goes out at load, otherwise on the first edge
  assign shift_out = (start & (state == spi_link_pkg::EDGE_IDLE) & ~cpha)
                   | (tick & (lead_edge == cpha));
  assign sample    = tick & (lead_edge != cpha);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= spi_link_pkg::EDGE_IDLE;
      edge_cnt <= '0;
      sclk     <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        spi_link_pkg::EDGE_IDLE: begin
          sclk     <= cpol;  // Follow the configured idle level
          edge_cnt <= '0;
          if (start)
            state <= spi_link_pkg::EDGE_SHIFT;
        end
        spi_link_pkg::EDGE_SHIFT: begin
          if (tick) begin
            sclk     <= ~sclk;
            edge_cnt <= edge_cnt + 4'd1;
            if (edge_cnt == 4'd15) begin
              state <= spi_link_pkg::EDGE_IDLE;
              done  <= 1'b1;  // Last sample lands on this edge too
            end
          end
        end
        default: state <= spi_link_pkg::EDGE_IDLE;
      endcase
    end
  end

  spi_sclk_timer #(
    .half_period(half_period)
  ) timer0 (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .tick  (tick)
  );

  spi_shifter shifter0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (start & (state == spi_link_pkg::EDGE_IDLE)),
    .tx_byte   (tx_byte),
    .lsb_first (conf[`SPI_CONF_LSB_FIRST]),
    .shift_out (shift_out),
    .sample    (sample),
    .miso      (miso),
    .mosi      (mosi),
    .rx_byte   (rx_byte)
  );

endmodule

`default_nettype wire

// ==== hdl/spi_shifter.sv ====
`default_nettype none

module spi_shifter (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  load,
  input  spi_link_pkg::byte_t  tx_byte,
  input  wire                  lsb_first,
  input  wire                  shift_out,
  input  wire                  sample,
  input  wire                  miso,
  output logic                 mosi,
  output spi_link_pkg::byte_t  rx_byte
);

  spi_link_pkg::byte_t tx_q;
  spi_link_pkg::byte_t tx_src;
  spi_link_pkg::byte_t tx_next;
  logic                head;

  // Load and shift can come together, then the new byte shifts at once
  assign tx_src = load ? tx_byte : tx_q;

  always_comb begin
    if (lsb_first) begin
      head    = tx_src[0];
      tx_next = {1'b0, tx_src[7:1]};
    end else begin
      head    = tx_src[7];
      tx_next = {tx_src[6:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (load || shift_out)
      tx_q <= shift_out ? tx_next : tx_src;
    if (sample) begin
      if (lsb_first)
        rx_byte <= {miso, rx_byte[7:1]};  // First bit ends up in bit 0
      else
        rx_byte <= {rx_byte[6:0], miso};
    end
  end

  // Registered data line, low out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mosi <= 1'b0;
    end else if (shift_out) begin
      mosi <= head;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/spi_sclk_timer.sv ====
`default_nettype none

module spi_sclk_timer #(
  parameter int half_period = 2
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  run,
  output logic tick
);

  // At least one bit, even for a period of one cycle
  localparam int CNT_W = (half_period > 1) ? $clog2(half_period) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(half_period - 1);

  logic [CNT_W-1:0] count;

  // One pulse at the end of each half period
  assign tick = run & (count == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= RELOAD;
    end else if (!run) begin
      count <= RELOAD;  // Next byte starts a full half period
    end else if (count == '0) begin
      count <= RELOAD;
    end else begin
      count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/spi_link_pkg.sv ====
`default_nettype none

package spi_link_pkg;

  localparam int BYTE_W = 8;
  localparam int SS_W   = 2;
  localparam int CONF_W = 16;

  typedef logic [BYTE_W-1:0] byte_t;  // One serial byte
  typedef logic [SS_W-1:0]   ss_t;    // Active low selects
  typedef logic [CONF_W-1:0] conf_t;  // Only cpol, cpha, lsb_first used

  // Host-side transfer states, visible in the status word
  typedef enum logic [1:0] {
    XFER_IDLE     = 2'd0,
    XFER_BUSY     = 2'd1,
    XFER_COMPLETE = 2'd2,
    XFER_RELEASE  = 2'd3
  } xfer_state_t;

  // Byte transceiver states
  typedef enum logic {
    EDGE_IDLE  = 1'b0,
    EDGE_SHIFT = 1'b1
  } edge_state_t;

endpackage

`default_nettype wire

// ==== hdl/spi_bus_pkg.sv ====
`default_nettype none

package spi_bus_pkg;

  // Register bus field widths
  localparam int ADDR_W = 4;
  localparam int WORD_W = 16;

  // Register address on the host bus
  typedef logic [ADDR_W-1:0] addr_t;

  // Data word, in both directions
  typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire

// ==== hdl/spi_defs.svh ====
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// Host register map, one word per register
`define SPI_ADDR_DATA 4'h0
`define SPI_ADDR_SS   4'h2
`define SPI_ADDR_CONF 4'h4

// Bit positions inside the configuration word
`define SPI_CONF_CPOL      0  // Idle level of sclk
`define SPI_CONF_CPHA      1  // 1 = sample on trailing edge
`define SPI_CONF_LSB_FIRST 2

// Both slave selects inactive
`define SPI_SS_RESET 2'b11

// Default system clock and serial clock rates in Hz
`define SPI_DEF_CLKFREQ 50000000
`define SPI_DEF_SPEED   500000

`endif
